// File: verilog/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// datapath width, also the PC width
`define DATA_WIDTH 16

// architectural registers r0..r7
`define REG_COUNT 8

// first fetch address
`define PC_RESET 0

`endif

// File: verilog/isa_pkg.sv
`default_nettype none

package isa_pkg;

  // format class of an instruction word
  typedef enum logic [1:0] {
    CLASS_R      = 2'd0,
    CLASS_I      = 2'd1,
    CLASS_BRANCH = 2'd2,
    CLASS_JUMP   = 2'd3
  } instr_class_t;

  localparam logic [4:0] OP_NOP   = 5'b00000;  // all-zero word is a nop
  localparam logic [4:0] OP_HALT  = 5'b00001;
  localparam logic [4:0] OP_ADD   = 5'b00100;
  localparam logic [4:0] OP_SUB   = 5'b00101;
  localparam logic [4:0] OP_AND   = 5'b00110;
  localparam logic [4:0] OP_OR    = 5'b00111;
  localparam logic [4:0] OP_XOR   = 5'b01000;
  localparam logic [4:0] OP_SLL   = 5'b01001;
  localparam logic [4:0] OP_SRL   = 5'b01010;
  localparam logic [4:0] OP_ADDI  = 5'b01100;
  localparam logic [4:0] OP_SUBI  = 5'b01101;
  localparam logic [4:0] OP_LOAD  = 5'b10000;
  localparam logic [4:0] OP_STORE = 5'b10001;
  localparam logic [4:0] OP_BEQZ  = 5'b10100;
  localparam logic [4:0] OP_BNEZ  = 5'b10101;
  localparam logic [4:0] OP_JUMP  = 5'b11000;

  localparam int OPCODE_MSB = 15;
  localparam int OPCODE_LSB = 11;
  localparam int RS_MSB     = 10;
  localparam int RS_LSB     = 8;
  localparam int RT_MSB     = 7;
  localparam int RT_LSB     = 5;
  localparam int RD_MSB     = 4;
  localparam int RD_LSB     = 2;
  localparam int IMM_W      = 5;   // I-format, sign-extended
  localparam int BR_OFF_W   = 8;   // branch offset, sign-extended
  localparam int JMP_OFF_W  = 11;  // jump offset, sign-extended

endpackage

`default_nettype wire

// File: verilog/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

  `include "cpu_settings.svh"

  typedef logic [`DATA_WIDTH-1:0] word_t;
  typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;

  // zero is nop so a cleared ID/EX register does nothing
  typedef enum logic [4:0] {
    ALU_NOP   = 5'd0,
    ALU_ADD   = 5'd1,
    ALU_SUB   = 5'd2,
    ALU_AND   = 5'd3,
    ALU_OR    = 5'd4,
    ALU_XOR   = 5'd5,
    ALU_SLL   = 5'd6,
    ALU_SRL   = 5'd7,
    ALU_ADDI  = 5'd8,
    ALU_SUBI  = 5'd9,
    ALU_BEQZ  = 5'd10,
    ALU_BNEZ  = 5'd11,
    ALU_JUMP  = 5'd12,
    ALU_LOAD  = 5'd13,
    ALU_STORE = 5'd14,
    ALU_HALT  = 5'd15
  } alu_op_t;

endpackage

`default_nettype wire

// File: verilog/regfile.sv
`default_nettype none
`timescale 1ns/100ps

`include "cpu_settings.svh"

module regfile
  import pipe_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  reg_idx_t read_idx1,
  input  reg_idx_t read_idx2,
  output word_t    read_data1,
  output word_t    read_data2,
  input  reg_idx_t write_idx,
  input  word_t    write_data,
  input  logic     write_en
);

  word_t regs [`REG_COUNT];

  // no write-to-read bypass, a dependent read waits for the edge
  assign read_data1 = regs[read_idx1];
  assign read_data2 = regs[read_idx2];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en) begin
      regs[write_idx] <= write_data;  // r0 is writable like any other
    end
  end

endmodule

`default_nettype wire

// File: verilog/decode_unit.sv
`default_nettype none
`timescale 1ns/100ps

module decode_unit
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  word_t        instr,
  output reg_idx_t     rs,
  output reg_idx_t     rt,
  output reg_idx_t     rd,
  output logic         rs_valid,
  output logic         rt_valid,
  output logic         rd_valid,
  output reg_idx_t     write_reg,
  output word_t        imm,
  output word_t        jump_offset,
  output instr_class_t instr_class,
  output alu_op_t      alu_op,
  output logic         alu_src,
  output logic         branch,
  output logic         jump,
  output logic         mem_read,
  output logic         mem_write,
  output logic         mem_to_reg,
  output logic         reg_write,
  output logic         halt
);

  logic [4:0] opcode;

  assign opcode = instr[OPCODE_MSB:OPCODE_LSB];
  assign rs     = instr[RS_MSB:RS_LSB];
  assign rt     = instr[RT_MSB:RT_LSB];
  assign rd     = instr[RD_MSB:RD_LSB];

  assign imm = (instr_class == CLASS_BRANCH) ? word_t'($signed(instr[BR_OFF_W-1:0]))
                                             : word_t'($signed(instr[IMM_W-1:0]));
  assign jump_offset = word_t'($signed(instr[JMP_OFF_W-1:0]));
  assign write_reg   = rd_valid ? rd : rt;  // I-format results go to rt

  always_comb begin
    case (opcode)
      OP_ADD:   alu_op = ALU_ADD;
      OP_SUB:   alu_op = ALU_SUB;
      OP_AND:   alu_op = ALU_AND;
      OP_OR:    alu_op = ALU_OR;
      OP_XOR:   alu_op = ALU_XOR;
      OP_SLL:   alu_op = ALU_SLL;
      OP_SRL:   alu_op = ALU_SRL;
      OP_ADDI:  alu_op = ALU_ADDI;
      OP_SUBI:  alu_op = ALU_SUBI;
      OP_LOAD:  alu_op = ALU_LOAD;
      OP_STORE: alu_op = ALU_STORE;
      OP_BEQZ:  alu_op = ALU_BEQZ;
      OP_BNEZ:  alu_op = ALU_BNEZ;
      OP_JUMP:  alu_op = ALU_JUMP;
      OP_HALT:  alu_op = ALU_HALT;
      default:  alu_op = ALU_NOP;  // unknown opcodes too
    endcase
  end

  always_comb begin
    instr_class = CLASS_R;
    rs_valid    = 1'b0;
    rt_valid    = 1'b0;
    rd_valid    = 1'b0;
    alu_src     = 1'b0;
    branch      = 1'b0;
    jump        = 1'b0;
    mem_read    = 1'b0;
    mem_write   = 1'b0;
    mem_to_reg  = 1'b0;
    reg_write   = 1'b0;
    halt        = 1'b0;
    case (opcode)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL: begin
        rs_valid  = 1'b1;
        rt_valid  = 1'b1;
        rd_valid  = 1'b1;
        reg_write = 1'b1;
      end
      OP_ADDI, OP_SUBI: begin
        instr_class = CLASS_I;
        rs_valid    = 1'b1;
        alu_src     = 1'b1;
        reg_write   = 1'b1;
      end
      OP_LOAD: begin
        instr_class = CLASS_I;
        rs_valid    = 1'b1;
        alu_src     = 1'b1;
        mem_read    = 1'b1;
        mem_to_reg  = 1'b1;
        reg_write   = 1'b1;  // rt is still a pending destination
      end
      OP_STORE: begin
        instr_class = CLASS_I;
        rs_valid    = 1'b1;
        rt_valid    = 1'b1;  // store data
        alu_src     = 1'b1;
        mem_write   = 1'b1;
      end
      OP_BEQZ, OP_BNEZ: begin
        instr_class = CLASS_BRANCH;
        rs_valid    = 1'b1;
        branch      = 1'b1;
      end
      OP_JUMP: begin
        instr_class = CLASS_JUMP;
        jump        = 1'b1;
      end
      OP_HALT: begin
        halt = 1'b1;
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/hazard_unit.sv
`default_nettype none
`timescale 1ns/100ps

module hazard_unit
  import pipe_pkg::*;
(
  input  reg_idx_t rs,
  input  reg_idx_t rt,
  input  logic     rs_valid,
  input  logic     rt_valid,
  input  reg_idx_t ex_write_reg,
  input  logic     ex_reg_write,
  input  logic     redirect,
  output logic     stall,
  output logic     bubble
);

  logic rs_hit;
  logic rt_hit;
  logic raw;

  // only the EX instruction matters, older ones have already written back
  assign rs_hit = rs_valid && (rs == ex_write_reg);
  assign rt_hit = rt_valid && (rt == ex_write_reg);
  assign raw    = ex_reg_write && (rs_hit || rt_hit);

  assign stall  = raw;
  assign bubble = raw || redirect;  // on redirect the ID word is wrong path

endmodule

`default_nettype wire

// File: verilog/idex_reg.sv
`default_nettype none
`timescale 1ns/100ps

`include "cpu_settings.svh"

module idex_reg
  import pipe_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     bubble,
  input  word_t    pc_in,
  input  word_t    read1_in,
  input  word_t    read2_in,
  input  word_t    imm_in,
  input  word_t    jump_offset_in,
  input  reg_idx_t write_reg_in,
  input  alu_op_t  alu_op_in,
  input  logic     alu_src_in,
  input  logic     branch_in,
  input  logic     jump_in,
  input  logic     mem_read_in,
  input  logic     mem_write_in,
  input  logic     mem_to_reg_in,
  input  logic     reg_write_in,
  input  logic     halt_in,
  output word_t    pc_out,
  output word_t    read1_out,
  output word_t    read2_out,
  output word_t    imm_out,
  output word_t    jump_offset_out,
  output reg_idx_t write_reg_out,
  output alu_op_t  alu_op_out,
  output logic     alu_src_out,
  output logic     branch_out,
  output logic     jump_out,
  output logic     mem_read_out,
  output logic     mem_write_out,
  output logic     mem_to_reg_out,
  output logic     reg_write_out,
  output logic     halt_out
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_out          <= word_t'(`PC_RESET);
      read1_out       <= '0;
      read2_out       <= '0;
      imm_out         <= '0;
      jump_offset_out <= '0;
      write_reg_out   <= '0;
      alu_op_out      <= ALU_NOP;
      alu_src_out     <= 1'b0;
      branch_out      <= 1'b0;
      jump_out        <= 1'b0;
      mem_read_out    <= 1'b0;
      mem_write_out   <= 1'b0;
      mem_to_reg_out  <= 1'b0;
      reg_write_out   <= 1'b0;
      halt_out        <= 1'b0;
    end else begin
      pc_out          <= pc_in;
      read1_out       <= read1_in;
      read2_out       <= read2_in;
      imm_out         <= imm_in;
      jump_offset_out <= jump_offset_in;
      write_reg_out   <= write_reg_in;
      alu_op_out      <= alu_op_in;
      alu_src_out     <= alu_src_in;
      mem_read_out    <= mem_read_in;
      mem_to_reg_out  <= mem_to_reg_in;
      // a bubble keeps the fields but drops every side effect
      branch_out      <= branch_in && !bubble;
      jump_out        <= jump_in && !bubble;
      mem_write_out   <= mem_write_in && !bubble;
      reg_write_out   <= reg_write_in && !bubble;
      halt_out        <= halt_in && !bubble;
    end
  end

endmodule

`default_nettype wire

// File: verilog/alu.sv
`default_nettype none
`timescale 1ns/100ps

module alu
  import pipe_pkg::*;
(
  input  alu_op_t alu_op,
  input  logic    alu_src,
  input  word_t   read1,
  input  word_t   read2,
  input  word_t   imm,
  input  word_t   jump_offset,
  input  word_t   pc,
  input  logic    branch,
  input  logic    jump,
  input  logic    halt,
  output word_t   result,
  output logic    redirect,
  output word_t   redirect_pc
);

  localparam int SHAMT_W = $clog2($bits(word_t));

  word_t operand_b;
  word_t seq_pc;
  logic  is_zero;
  logic  taken;

  assign operand_b = alu_src ? imm : read2;
  assign seq_pc    = pc + word_t'(1);
  assign is_zero   = (read1 == '0);

  always_comb begin
    case (alu_op)
      ALU_ADD, ALU_ADDI, ALU_LOAD, ALU_STORE: result = read1 + operand_b;  // add or address
      ALU_SUB, ALU_SUBI: result = read1 - operand_b;
      ALU_AND: result = read1 & operand_b;
      ALU_OR:  result = read1 | operand_b;
      ALU_XOR: result = read1 ^ operand_b;
      ALU_SLL: result = read1 << operand_b[SHAMT_W-1:0];
      ALU_SRL: result = read1 >> operand_b[SHAMT_W-1:0];
      ALU_BEQZ, ALU_BNEZ, ALU_JUMP: result = seq_pc;  // link value
      default: result = '0;
    endcase
  end

  assign taken = branch && ((alu_op == ALU_BEQZ) ? is_zero : !is_zero);

  // halt spins on its own pc so nothing behind it reaches EX with effects
  assign redirect    = taken || jump || halt;
  assign redirect_pc = halt ? pc :
                       jump ? seq_pc + jump_offset :
                              seq_pc + imm;

endmodule

`default_nettype wire

// File: verilog/decode_execute_top.sv
`default_nettype none
`timescale 1ns/100ps

module decode_execute_top
  import pipe_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  word_t    instr,
  input  word_t    pc,
  output logic     stall,
  output word_t    ex_pc,
  output word_t    ex_result,
  output word_t    ex_store_data,
  output reg_idx_t ex_write_reg,
  output logic     ex_reg_write,
  output logic     ex_mem_read,
  output logic     ex_mem_write,
  output logic     redirect,
  output word_t    redirect_pc,
  output logic     halted
);

  reg_idx_t id_rs;
  reg_idx_t id_rt;
  logic     id_rs_valid;
  logic     id_rt_valid;
  reg_idx_t id_write_reg;
  word_t    id_imm;
  word_t    id_jump_offset;
  alu_op_t  id_alu_op;
  logic     id_alu_src;
  logic     id_branch;
  logic     id_jump;
  logic     id_mem_read;
  logic     id_mem_write;
  logic     id_mem_to_reg;
  logic     id_reg_write;
  logic     id_halt;
  word_t    id_read1;
  word_t    id_read2;
  logic     bubble;

  word_t    ex_read1;
  word_t    ex_imm;
  word_t    ex_jump_offset;
  alu_op_t  ex_alu_op;
  logic     ex_alu_src;
  logic     ex_branch;
  logic     ex_jump;
  logic     ex_mem_to_reg;
  logic     ex_dest_pending;  // EX owns a destination, loads included
  logic     ex_halt;
  logic     halted_r;

  regfile i_regfile (
    .clk        (clk),
    .rst_n      (rst_n),
    .read_idx1  (id_rs),
    .read_idx2  (id_rt),
    .read_data1 (id_read1),
    .read_data2 (id_read2),
    .write_idx  (ex_write_reg),
    .write_data (ex_result),
    .write_en   (ex_reg_write)
  );

  decode_unit i_decode_unit (
    .instr       (instr),
    .rs          (id_rs),
    .rt          (id_rt),
    .rd          (),
    .rs_valid    (id_rs_valid),
    .rt_valid    (id_rt_valid),
    .rd_valid    (),
    .write_reg   (id_write_reg),
    .imm         (id_imm),
    .jump_offset (id_jump_offset),
    .instr_class (),
    .alu_op      (id_alu_op),
    .alu_src     (id_alu_src),
    .branch      (id_branch),
    .jump        (id_jump),
    .mem_read    (id_mem_read),
    .mem_write   (id_mem_write),
    .mem_to_reg  (id_mem_to_reg),
    .reg_write   (id_reg_write),
    .halt        (id_halt)
  );

  hazard_unit i_hazard_unit (
    .rs           (id_rs),
    .rt           (id_rt),
    .rs_valid     (id_rs_valid),
    .rt_valid     (id_rt_valid),
    .ex_write_reg (ex_write_reg),
    .ex_reg_write (ex_dest_pending),
    .redirect     (redirect),
    .stall        (stall),
    .bubble       (bubble)
  );

  idex_reg i_idex_reg (
    .clk             (clk),
    .rst_n           (rst_n),
    .bubble          (bubble),
    .pc_in           (pc),
    .read1_in        (id_read1),
    .read2_in        (id_read2),
    .imm_in          (id_imm),
    .jump_offset_in  (id_jump_offset),
    .write_reg_in    (id_write_reg),
    .alu_op_in       (id_alu_op),
    .alu_src_in      (id_alu_src),
    .branch_in       (id_branch),
    .jump_in         (id_jump),
    .mem_read_in     (id_mem_read),
    .mem_write_in    (id_mem_write),
    .mem_to_reg_in   (id_mem_to_reg),
    .reg_write_in    (id_reg_write),
    .halt_in         (id_halt),
    .pc_out          (ex_pc),
    .read1_out       (ex_read1),
    .read2_out       (ex_store_data),
    .imm_out         (ex_imm),
    .jump_offset_out (ex_jump_offset),
    .write_reg_out   (ex_write_reg),
    .alu_op_out      (ex_alu_op),
    .alu_src_out     (ex_alu_src),
    .branch_out      (ex_branch),
    .jump_out        (ex_jump),
    .mem_read_out    (ex_mem_read),
    .mem_write_out   (ex_mem_write),
    .mem_to_reg_out  (ex_mem_to_reg),
    .reg_write_out   (ex_dest_pending),
    .halt_out        (ex_halt)
  );

  alu i_alu (
    .alu_op      (ex_alu_op),
    .alu_src     (ex_alu_src),
    .read1       (ex_read1),
    .read2       (ex_store_data),
    .imm         (ex_imm),
    .jump_offset (ex_jump_offset),
    .pc          (ex_pc),
    .branch      (ex_branch),
    .jump        (ex_jump),
    .halt        (ex_halt),
    .result      (ex_result),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  // load data never comes back, so loads stop short of the regfile
  assign ex_reg_write = ex_dest_pending && !ex_mem_to_reg;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      halted_r <= 1'b0;
    end else if (ex_halt) begin
      halted_r <= 1'b1;
    end
  end

  assign halted = halted_r || ex_halt;  // sticky once a halt reaches EX

endmodule

`default_nettype wire

// File: bench/decode_execute_sva.sv
`default_nettype none
`timescale 1ns/100ps

module decode_execute_sva (
  input logic clk,
  input logic rst_n,
  input logic stall,
  input logic bubble,
  input logic ex_reg_write,
  input logic ex_mem_write,
  input logic halted
);

  // the stalled copy entering EX has to be squashed
  a_stall_bubble: assert property (@(posedge clk) disable iff (!rst_n) stall |-> bubble)
    else $error("stall raised without bubble");

  a_bubble_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    bubble |=> !ex_reg_write && !ex_mem_write)
    else $error("write in EX on the cycle after a bubble");

  a_halted_sticky: assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted)
    else $error("halted fell");

endmodule

bind decode_execute_top decode_execute_sva i_decode_execute_sva (
  .clk          (clk),
  .rst_n        (rst_n),
  .stall        (stall),
  .bubble       (bubble),
  .ex_reg_write (ex_reg_write),
  .ex_mem_write (ex_mem_write),
  .halted       (halted)
);

`default_nettype wire

// File: bench/decode_execute_tb.sv
`default_nettype none
`timescale 1ns/100ps

`include "cpu_settings.svh"

module decode_execute_tb
  import isa_pkg::*;
  import pipe_pkg::*;
();

  localparam int MEM_DEPTH  = 256;
  localparam int RAND_COUNT = 40;
  localparam int SEED       = 99912;
  localparam logic [1:0] EV_REG   = 2'd0;
  localparam logic [1:0] EV_STORE = 2'd1;
  localparam logic [1:0] EV_LOAD  = 2'd2;

  logic     clk   = 1'b0;
  logic     rst_n = 1'b0;
  word_t    instr = '0;
  word_t    pc    = word_t'(`PC_RESET);
  logic     stall;
  word_t    ex_pc;
  word_t    ex_result;
  word_t    ex_store_data;
  reg_idx_t ex_write_reg;
  logic     ex_reg_write;
  logic     ex_mem_read;
  logic     ex_mem_write;
  logic     redirect;
  word_t    redirect_pc;
  logic     halted;

  word_t      imem [MEM_DEPTH];
  logic [1:0] exp_kind [$];
  word_t      exp_addr [$];  // register index for register writes
  word_t      exp_data [$];
  word_t      exp_halt_pc;
  int prog_len;
  int cycle_limit;
  int cycles            = 0;
  int events_seen       = 0;
  int exp_stalls        = 0;
  int stalls_seen       = 0;
  int value_errors      = 0;
  int missing_errors    = 0;
  int unexpected_errors = 0;
  int timeouts          = 0;
  bit halt_seen         = 1'b0;

  decode_execute_top i_decode_execute_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr         (instr),
    .pc            (pc),
    .stall         (stall),
    .ex_pc         (ex_pc),
    .ex_result     (ex_result),
    .ex_store_data (ex_store_data),
    .ex_write_reg  (ex_write_reg),
    .ex_reg_write  (ex_reg_write),
    .ex_mem_read   (ex_mem_read),
    .ex_mem_write  (ex_mem_write),
    .redirect      (redirect),
    .redirect_pc   (redirect_pc),
    .halted        (halted)
  );

  always #2 clk = ~clk;

  always @(posedge clk) cycles <= cycles + 1;

  function automatic word_t enc_r(logic [4:0] op, int rs, int rt, int rd);
    return {op, 3'(rs), 3'(rt), 3'(rd), 2'b00};
  endfunction

  function automatic word_t enc_i(logic [4:0] op, int rs, int rt, int imm);
    return {op, 3'(rs), 3'(rt), 5'(imm)};  // I-format writes rt
  endfunction

  function automatic word_t enc_b(logic [4:0] op, int rs, int off);
    return {op, 3'(rs), 8'(off)};
  endfunction

  function automatic word_t enc_j(int off);
    return {OP_JUMP, 11'(off)};
  endfunction

  function automatic word_t sext(word_t w, int bits);
    word_t v;
    v = w;
    for (int k = bits; k < `DATA_WIDTH; k++) begin
      v[k] = w[bits-1];
    end
    return v;
  endfunction

  function automatic word_t fetch(word_t addr);
    return imem[addr[7:0]];
  endfunction

  function automatic string kind_name(logic [1:0] kind);
    return (kind == EV_REG) ? "reg write" : (kind == EV_STORE) ? "store" : "load";
  endfunction

  task automatic load_program();
    logic [4:0] rand_ops [7];
    int p;
    int prev_dst;
    int pick;
    int rs;
    int rt;
    int rd;
    rand_ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL};
    for (int a = 0; a < MEM_DEPTH; a++) begin
      imem[a] = {OP_NOP, 11'(a)};  // nop with the address in the low bits
    end
    imem[0]  = enc_i(OP_ADDI, 0, 1, 5);
    imem[1]  = enc_i(OP_ADDI, 0, 2, -3);
    imem[2]  = enc_r(OP_ADD, 1, 2, 3);  // needs r2 from the line above
    imem[3]  = enc_r(OP_SUB, 3, 1, 4);
    imem[4]  = enc_r(OP_AND, 4, 1, 5);
    imem[5]  = enc_r(OP_OR, 5, 2, 6);
    imem[6]  = enc_r(OP_XOR, 6, 4, 7);
    imem[7]  = enc_i(OP_ADDI, 0, 1, 3);
    imem[8]  = enc_r(OP_SLL, 4, 1, 2);
    imem[9]  = enc_r(OP_SRL, 4, 1, 3);
    imem[10] = enc_i(OP_STORE, 1, 3, 2);  // store data hazard on r3
    imem[11] = enc_i(OP_LOAD, 2, 5, -1);
    imem[12] = enc_b(OP_BEQZ, 0, 2);  // taken
    imem[13] = enc_i(OP_ADDI, 7, 7, 1);  // wrong path
    imem[14] = enc_i(OP_STORE, 7, 7, 0);
    imem[15] = enc_b(OP_BNEZ, 0, 5);  // not taken
    imem[16] = enc_b(OP_BEQZ, 1, 1);  // not taken
    imem[17] = enc_b(OP_BNEZ, 1, 2);  // taken
    imem[18] = enc_r(OP_ADD, 1, 1, 1);
    imem[19] = {OP_HALT, 11'd0};
    imem[20] = enc_i(OP_ADDI, 0, 0, 2);
    imem[21] = enc_i(OP_SUBI, 0, 0, 1);
    imem[22] = enc_b(OP_BNEZ, 0, -2);  // loops back once
    imem[23] = enc_j(3);
    imem[24] = {OP_HALT, 11'd0};  // wrong-path halt must be squashed
    imem[25] = enc_i(OP_STORE, 1, 2, 0);
    imem[26] = enc_r(OP_ADD, 2, 2, 2);
    p = 27;
    prev_dst = 1;
    for (int i = 0; i < RAND_COUNT; i++) begin
      pick = int'($urandom % 10);
      rs = ($urandom % 2 == 0) ? prev_dst : int'($urandom % 8);  // often back-to-back
      rt = int'($urandom % 8);
      rd = int'($urandom % 8);
      if (pick < 7) begin
        imem[p] = enc_r(rand_ops[pick], rs, rt, rd);
        prev_dst = rd;
      end else if (pick < 9) begin
        imem[p] = enc_i((pick == 7) ? OP_ADDI : OP_SUBI, rs, rt, int'($urandom % 32));
        prev_dst = rt;
      end else begin
        imem[p] = enc_i(OP_STORE, rs, prev_dst, int'($urandom % 32));
      end
      p++;
    end
    imem[p] = {OP_HALT, 11'd0};
    prog_len = p + 1;
  endtask

  // interprets the program and queues every write it should make
  function automatic word_t run_reference();
    word_t regs [8];
    word_t rpc;
    word_t w;
    word_t a;
    word_t b;
    word_t res;
    logic [4:0] op;
    logic [2:0] dst;
    logic [2:0] last_dst;
    logic wr;
    logic last_wr;
    logic rs_used;
    logic rt_used;
    for (int i = 0; i < 8; i++) begin
      regs[i] = '0;
    end
    rpc = word_t'(`PC_RESET);
    last_wr  = 1'b0;
    last_dst = '0;
    for (int steps = 0; steps < 2000; steps++) begin
      w   = fetch(rpc);
      op  = w[15:11];
      a   = regs[w[10:8]];
      b   = regs[w[7:5]];
      wr  = 1'b1;
      dst = w[4:2];
      res = '0;
      if (op == OP_HALT) begin
        return rpc;
      end
      rt_used = (op == OP_ADD) || (op == OP_SUB) || (op == OP_AND) || (op == OP_OR)
                || (op == OP_XOR) || (op == OP_SLL) || (op == OP_SRL) || (op == OP_STORE);
      rs_used = rt_used || (op == OP_ADDI) || (op == OP_SUBI) || (op == OP_LOAD)
                || (op == OP_BEQZ) || (op == OP_BNEZ);
      // a source written by the instruction just before costs one stall cycle
      if (last_wr && ((rs_used && w[10:8] == last_dst) ||
                      (rt_used && w[7:5] == last_dst))) begin
        exp_stalls++;
      end
      case (op)
        OP_ADD: res = a + b;
        OP_SUB: res = a - b;
        OP_AND: res = a & b;
        OP_OR:  res = a | b;
        OP_XOR: res = a ^ b;
        OP_SLL: res = a << b[3:0];
        OP_SRL: res = a >> b[3:0];
        OP_ADDI, OP_SUBI: begin
          res = (op == OP_ADDI) ? a + sext(w, 5) : a - sext(w, 5);
          dst = w[7:5];
        end
        default: wr = 1'b0;
      endcase
      if (wr) begin
        regs[dst] = res;
        exp_kind.push_back(EV_REG);
        exp_addr.push_back(word_t'(dst));
        exp_data.push_back(res);
      end
      last_wr  = wr || (op == OP_LOAD);
      last_dst = (op == OP_LOAD) ? w[7:5] : dst;
      if (op == OP_LOAD || op == OP_STORE) begin
        exp_kind.push_back((op == OP_LOAD) ? EV_LOAD : EV_STORE);
        exp_addr.push_back(a + sext(w, 5));
        exp_data.push_back((op == OP_LOAD) ? word_t'(0) : b);  // loads carry no data
      end
      if ((op == OP_BEQZ && a == '0) || (op == OP_BNEZ && a != '0)) begin
        rpc = rpc + word_t'(1) + sext(w, 8);
      end else if (op == OP_JUMP) begin
        rpc = rpc + word_t'(1) + sext(w, 11);
      end else begin
        rpc = rpc + word_t'(1);
      end
    end
    return rpc;
  endfunction

  task automatic check_event(logic [1:0] kind, word_t addr, word_t data);
    logic [1:0] k;
    word_t a;
    word_t d;
    events_seen++;
    if (exp_kind.size() == 0) begin
      unexpected_errors++;
      $display("unexpected %s at %0t ns, no write was left to expect", kind_name(kind), $time);
    end else begin
      k = exp_kind.pop_front();
      a = exp_addr.pop_front();
      d = exp_data.pop_front();
      if (k != kind || a != addr || d != data) begin
        value_errors++;
        $display("FAILED at %0t ns: expected %s %h/%h, got %s %h/%h",
                 $time, kind_name(k), a, d, kind_name(kind), addr, data);
      end
    end
  endtask

  // fetch side plays the instruction memory
  always @(posedge clk) begin
    if (!rst_n) begin
      pc    <= word_t'(`PC_RESET);
      instr <= fetch(word_t'(`PC_RESET));
    end else if (redirect) begin
      pc    <= redirect_pc;
      instr <= fetch(redirect_pc);
    end else if (!stall) begin
      pc    <= pc + word_t'(1);
      instr <= fetch(pc + word_t'(1));
    end
  end

  // compare at mid-cycle where EX outputs are settled
  always @(negedge clk) begin
    if (rst_n) begin
      if (stall) stalls_seen++;
      if (ex_reg_write) check_event(EV_REG, word_t'(ex_write_reg), ex_result);
      if (ex_mem_write) check_event(EV_STORE, ex_result, ex_store_data);
      if (ex_mem_read) check_event(EV_LOAD, ex_result, word_t'(0));
      if (halted && !halt_seen) begin
        halt_seen = 1'b1;
        if (ex_pc != exp_halt_pc) begin
          value_errors++;
          $display("FAILED at %0t ns: halted at pc %h, expected %h", $time, ex_pc, exp_halt_pc);
        end
      end
    end
  end

  initial begin
    void'($urandom(SEED));
    load_program();
    exp_halt_pc = run_reference();
    cycle_limit = 3 * prog_len + 50;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    while (!halt_seen && cycles < cycle_limit) @(posedge clk);
    if (!halt_seen) begin
      timeouts++;
      $display("timeout: halted did not rise within %0d cycles", cycle_limit);
    end else begin
      repeat (8) @(posedge clk);  // nothing may write after the halt
      if (stalls_seen != exp_stalls) begin
        value_errors++;
        $display("FAILED at %0t ns: %0d stall cycles, expected %0d",
                 $time, stalls_seen, exp_stalls);
      end
    end
    if (exp_kind.size() != 0) begin
      missing_errors += exp_kind.size();
      $display("%0d expected writes never appeared", exp_kind.size());
    end
    $display("%0d events, %0d value errors, %0d missing, %0d unexpected, %0d timeouts",
             events_seen, value_errors, missing_errors, unexpected_errors, timeouts);
    if (value_errors + missing_errors + unexpected_errors + timeouts == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+verilog
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/regfile.sv
verilog/decode_unit.sv
verilog/hazard_unit.sv
verilog/idex_reg.sv
verilog/alu.sv
verilog/decode_execute_top.sv
bench/decode_execute_sva.sv
bench/decode_execute_tb.sv

// File: Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing -j 0
LINT_FLAGS = --lint-only -Wall --timing
TOP        = decode_execute_tb
FILELIST   = vlog.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = TEST PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
